/* list.f */
source/cpu_pkg.sv
source/sram_dual_port.sv
source/register_file.sv
source/decode_unit.sv
source/hazard_unit.sv
source/execute_unit.sv
source/cpu_top.sv
verif/cpu_tb.sv

/* source/cpu_pkg.sv */
//**************************************
// Shared widths, opcodes, control fields
// and pipeline register layouts
//**************************************
package cpu_pkg;

   localparam int XLEN = 64;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [31:0]     instr_t;
   typedef logic [4:0]      reg_addr_t;

   // Word index widths, byte addressed on both ports
   localparam int IMEM_ADDR_W = 9;
   localparam int DMEM_ADDR_W = 10;

   // Major opcodes of the supported subset
   localparam logic [6:0] OP_RTYPE = 7'b0110011;  // add sub and or
   localparam logic [6:0] OP_IMM   = 7'b0010011;  // addi
   localparam logic [6:0] OP_LOAD  = 7'b0000011;  // ld
   localparam logic [6:0] OP_STORE = 7'b0100011;  // sd

   localparam logic [2:0] FUNCT3_ADD = 3'b000;
   localparam logic [2:0] FUNCT3_AND = 3'b111;
   localparam logic [2:0] FUNCT3_OR  = 3'b110;

   localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_OR  = 2'd3
   } alu_op_e;

   // All zero means bubble
   typedef struct packed {
      logic    reg_write;
      logic    mem_to_reg;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src;    // Second operand from immediate
      alu_op_e alu_op;
   } ctrl_t;

   // Source of an EX operand
   typedef enum logic [1:0] {
      FWD_REG = 2'd0,
      FWD_MEM = 2'd1,
      FWD_WB  = 2'd2
   } fwd_sel_e;

   typedef struct packed {
      instr_t instr;
   } if_id_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      word_t     rs1_val;
      word_t     rs2_val;
      word_t     imm;
   } id_ex_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rd;
      word_t     alu_result;
      word_t     store_data;
   } ex_mem_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rd;
      word_t     load_data;
      word_t     alu_result;
   } mem_wb_t;

endpackage

/* source/cpu_top.sv */
//**************************************
// Five-stage RV64 pipeline top level
//**************************************
`timescale 1ns/1ps

module cpu_top (
   input  logic            clk,
   input  logic            reset,
   input  logic            enable,
   input  cpu_pkg::word_t  imem_addr_ext,
   input  logic            imem_wen_ext,
   input  cpu_pkg::instr_t imem_wdata_ext,
   output cpu_pkg::instr_t imem_rdata_ext,
   input  cpu_pkg::word_t  dmem_addr_ext,
   input  logic            dmem_wen_ext,
   input  cpu_pkg::word_t  dmem_wdata_ext,
   output cpu_pkg::word_t  dmem_rdata_ext
);

   cpu_pkg::word_t     pc;
   cpu_pkg::instr_t    fetched;
   cpu_pkg::if_id_t    if_id;
   cpu_pkg::id_ex_t    id_ex;
   cpu_pkg::ex_mem_t   ex_mem;
   cpu_pkg::mem_wb_t   mem_wb;

   cpu_pkg::ctrl_t     id_ctrl;
   cpu_pkg::reg_addr_t id_rs1;
   cpu_pkg::reg_addr_t id_rs2;
   cpu_pkg::reg_addr_t id_rd;
   logic               id_uses_rs2;
   cpu_pkg::word_t     id_imm;
   cpu_pkg::word_t     id_rdata_1;
   cpu_pkg::word_t     id_rdata_2;

   logic               stall;
   logic               front_en;   // PC and IF/ID advance
   cpu_pkg::fwd_sel_e  fwd_a;
   cpu_pkg::fwd_sel_e  fwd_b;
   cpu_pkg::ex_mem_t   ex_result;
   cpu_pkg::word_t     mem_rdata;
   cpu_pkg::word_t     wb_value;

   assign front_en = enable && !stall;

   // IF
   always_ff @(posedge clk) begin
      if (reset)
         pc <= '0;
      else if (front_en)
         pc <= pc + 64'd4;
   end

   sram_dual_port #(
      .word_type (cpu_pkg::instr_t),
      .DEPTH_W   (cpu_pkg::IMEM_ADDR_W)
   ) instruction_memory (
      .clk       (clk),
      .addr      (pc),
      .wen       (1'b0),            // Core never writes code
      .wdata     ('0),
      .rdata     (fetched),
      .addr_ext  (imem_addr_ext),
      .wen_ext   (imem_wen_ext),
      .wdata_ext (imem_wdata_ext),
      .rdata_ext (imem_rdata_ext)
   );

   always_ff @(posedge clk) begin
      if (reset)
         if_id <= '0;
      else if (front_en)
         if_id.instr <= fetched;
   end

   // ID
   decode_unit decoder (
      .instr    (if_id.instr),
      .ctrl     (id_ctrl),
      .rs1      (id_rs1),
      .rs2      (id_rs2),
      .rd       (id_rd),
      .uses_rs2 (id_uses_rs2),
      .imm      (id_imm)
   );

   register_file regfile (
      .clk     (clk),
      .reset   (reset),
      .raddr_1 (id_rs1),
      .raddr_2 (id_rs2),
      .rdata_1 (id_rdata_1),
      .rdata_2 (id_rdata_2),
      .wen     (mem_wb.ctrl.reg_write && enable),
      .waddr   (mem_wb.rd),
      .wdata   (wb_value)
   );

   hazard_unit hazards (
      .id_rs1      (id_rs1),
      .id_rs2      (id_rs2),
      .id_uses_rs2 (id_uses_rs2),
      .ex_stage    (id_ex),
      .mem_stage   (ex_mem),
      .wb_stage    (mem_wb),
      .stall       (stall),
      .fwd_a       (fwd_a),
      .fwd_b       (fwd_b)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         id_ex <= '0;
      end else if (enable) begin
         if (stall) begin
            id_ex <= '0;              // Bubble behind the load
         end else begin
            id_ex.ctrl    <= id_ctrl;
            id_ex.rs1     <= id_rs1;
            id_ex.rs2     <= id_rs2;
            id_ex.rd      <= id_rd;
            id_ex.rs1_val <= id_rdata_1;
            id_ex.rs2_val <= id_rdata_2;
            id_ex.imm     <= id_imm;
         end
      end
   end

   // EX
   execute_unit alu_stage (
      .ex_stage   (id_ex),
      .fwd_a      (fwd_a),
      .fwd_b      (fwd_b),
      .mem_result (ex_mem.alu_result),
      .wb_result  (wb_value),
      .result     (ex_result)
   );

   always_ff @(posedge clk) begin
      if (reset)
         ex_mem <= '0;
      else if (enable)
         ex_mem <= ex_result;
   end

   // MEM
   sram_dual_port #(
      .word_type (cpu_pkg::word_t),
      .DEPTH_W   (cpu_pkg::DMEM_ADDR_W)
   ) data_memory (
      .clk       (clk),
      .addr      (ex_mem.alu_result),
      .wen       (ex_mem.ctrl.mem_write && enable),
      .wdata     (ex_mem.store_data),
      .rdata     (mem_rdata),
      .addr_ext  (dmem_addr_ext),
      .wen_ext   (dmem_wen_ext),
      .wdata_ext (dmem_wdata_ext),
      .rdata_ext (dmem_rdata_ext)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_wb <= '0;
      end else if (enable) begin
         mem_wb.ctrl       <= ex_mem.ctrl;
         mem_wb.rd         <= ex_mem.rd;
         mem_wb.load_data  <= mem_rdata;
         mem_wb.alu_result <= ex_mem.alu_result;
      end
   end

   // WB, also forwarded into EX
   assign wb_value = mem_wb.ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

/* source/decode_unit.sv */
//**************************************
// Instruction decode, immediate extend
//**************************************
`timescale 1ns/1ps

module decode_unit (
   input  cpu_pkg::instr_t    instr,
   output cpu_pkg::ctrl_t     ctrl,
   output cpu_pkg::reg_addr_t rs1,
   output cpu_pkg::reg_addr_t rs2,
   output cpu_pkg::reg_addr_t rd,
   output logic               uses_rs2,
   output cpu_pkg::word_t     imm
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];
   assign rd  = instr[11:7];

   // Only R-type and stores read rs2
   assign uses_rs2 = (opcode == cpu_pkg::OP_RTYPE) || (opcode == cpu_pkg::OP_STORE);

   // S-type splits the offset around rd
   assign imm = (opcode == cpu_pkg::OP_STORE) ?
                {{52{instr[31]}}, instr[31:25], instr[11:7]} :
                {{52{instr[31]}}, instr[31:20]};

   always_comb begin
      ctrl = '0;
      case (opcode)
         cpu_pkg::OP_RTYPE: begin
            ctrl.reg_write = 1'b1;
            case (funct3)
               cpu_pkg::FUNCT3_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::FUNCT3_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
               default: begin
                  if (funct7 == cpu_pkg::FUNCT7_SUB)
                     ctrl.alu_op = cpu_pkg::ALU_SUB;
                  else
                     ctrl.alu_op = cpu_pkg::ALU_ADD;
               end
            endcase
         end
         cpu_pkg::OP_IMM: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         cpu_pkg::OP_LOAD: begin
            ctrl.reg_write  = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.alu_src    = 1'b1;   // Address is rs1 + offset
         end
         cpu_pkg::OP_STORE: begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         default: ctrl = '0;          // Unknown opcode acts as nop
      endcase
   end

endmodule

/* source/execute_unit.sv */
//**************************************
// Operand forwarding and ALU
//**************************************
`timescale 1ns/1ps

module execute_unit (
   input  cpu_pkg::id_ex_t   ex_stage,
   input  cpu_pkg::fwd_sel_e fwd_a,
   input  cpu_pkg::fwd_sel_e fwd_b,
   input  cpu_pkg::word_t    mem_result,
   input  cpu_pkg::word_t    wb_result,
   output cpu_pkg::ex_mem_t  result
);

   cpu_pkg::word_t operand_a;
   cpu_pkg::word_t rs2_fwd;
   cpu_pkg::word_t operand_b;
   cpu_pkg::word_t alu_out;

   function automatic cpu_pkg::word_t select_operand(cpu_pkg::fwd_sel_e sel,
                                                     cpu_pkg::word_t    reg_val,
                                                     cpu_pkg::word_t    mem_val,
                                                     cpu_pkg::word_t    wb_val);
      case (sel)
         cpu_pkg::FWD_MEM: return mem_val;
         cpu_pkg::FWD_WB:  return wb_val;
         default:          return reg_val;
      endcase
   endfunction

   assign operand_a = select_operand(fwd_a, ex_stage.rs1_val, mem_result, wb_result);
   assign rs2_fwd   = select_operand(fwd_b, ex_stage.rs2_val, mem_result, wb_result);

   // Immediate replaces rs2 for addi, ld and sd
   assign operand_b = ex_stage.ctrl.alu_src ? ex_stage.imm : rs2_fwd;

   always_comb begin
      alu_out = operand_a + operand_b;
      case (ex_stage.ctrl.alu_op)
         cpu_pkg::ALU_SUB: alu_out = operand_a - operand_b;
         cpu_pkg::ALU_AND: alu_out = operand_a & operand_b;
         cpu_pkg::ALU_OR:  alu_out = operand_a | operand_b;
         default:          alu_out = operand_a + operand_b;
      endcase
   end

   assign result.ctrl       = ex_stage.ctrl;
   assign result.rd         = ex_stage.rd;
   assign result.alu_result = alu_out;
   assign result.store_data = rs2_fwd;   // Forwarded value for sd

endmodule

/* source/hazard_unit.sv */
//**************************************
// Load-use stall and EX forwarding
//**************************************
`timescale 1ns/1ps

module hazard_unit (
   input  cpu_pkg::reg_addr_t id_rs1,
   input  cpu_pkg::reg_addr_t id_rs2,
   input  logic               id_uses_rs2,
   input  cpu_pkg::id_ex_t    ex_stage,
   input  cpu_pkg::ex_mem_t   mem_stage,
   input  cpu_pkg::mem_wb_t   wb_stage,
   output logic               stall,
   output cpu_pkg::fwd_sel_e  fwd_a,
   output cpu_pkg::fwd_sel_e  fwd_b
);

   logic rs1_hit;
   logic rs2_hit;

   // Newest producer first
   function automatic cpu_pkg::fwd_sel_e pick_source(cpu_pkg::reg_addr_t rs,
                                                     cpu_pkg::ex_mem_t   mem,
                                                     cpu_pkg::mem_wb_t   wb);
      if (mem.ctrl.reg_write && (mem.rd != '0) && (mem.rd == rs))
         return cpu_pkg::FWD_MEM;
      else if (wb.ctrl.reg_write && (wb.rd != '0) && (wb.rd == rs))
         return cpu_pkg::FWD_WB;
      else
         return cpu_pkg::FWD_REG;
   endfunction

   assign rs1_hit = (ex_stage.rd == id_rs1);
   assign rs2_hit = id_uses_rs2 && (ex_stage.rd == id_rs2);

   // Load data only exists after MEM, so hold ID one cycle
   assign stall = ex_stage.ctrl.mem_read && (ex_stage.rd != '0) && (rs1_hit || rs2_hit);

   assign fwd_a = pick_source(ex_stage.rs1, mem_stage, wb_stage);
   assign fwd_b = pick_source(ex_stage.rs2, mem_stage, wb_stage);

endmodule

/* source/register_file.sv */
//**************************************
// 32 x 64 write-through register file
//**************************************
`timescale 1ns/1ps

module register_file (
   input  logic               clk,
   input  logic               reset,
   input  cpu_pkg::reg_addr_t raddr_1,
   input  cpu_pkg::reg_addr_t raddr_2,
   output cpu_pkg::word_t     rdata_1,
   output cpu_pkg::word_t     rdata_2,
   input  logic               wen,
   input  cpu_pkg::reg_addr_t waddr,
   input  cpu_pkg::word_t     wdata
);

   cpu_pkg::word_t regs [32];

   // WB write is visible to ID in the same cycle
   assign rdata_1 = (raddr_1 == '0)             ? '0    :
                    (wen && (waddr == raddr_1)) ? wdata : regs[raddr_1];
   assign rdata_2 = (raddr_2 == '0)             ? '0    :
                    (wen && (waddr == raddr_2)) ? wdata : regs[raddr_2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (wen && (waddr != '0)) begin   // x0 stays zero
         regs[waddr] <= wdata;
      end
   end

endmodule

/* source/sram_dual_port.sv */
//**************************************
// Word memory, core and host ports
//**************************************
`timescale 1ns/1ps

module sram_dual_port #(
   parameter type word_type = cpu_pkg::word_t,
   parameter int  DEPTH_W   = cpu_pkg::DMEM_ADDR_W
) (
   input  logic           clk,
   input  cpu_pkg::word_t addr,
   input  logic           wen,
   input  word_type       wdata,
   output word_type       rdata,
   input  cpu_pkg::word_t addr_ext,
   input  logic           wen_ext,
   input  word_type       wdata_ext,
   output word_type       rdata_ext
);

   // Byte offset bits dropped from each address
   localparam int OFFSET_W = $clog2($bits(word_type) / 8);

   word_type             mem [2**DEPTH_W];
   logic [DEPTH_W-1:0]   idx;
   logic [DEPTH_W-1:0]   idx_ext;

   assign idx     = addr[OFFSET_W +: DEPTH_W];
   assign idx_ext = addr_ext[OFFSET_W +: DEPTH_W];

   assign rdata     = mem[idx];      // Combinational read
   assign rdata_ext = mem[idx_ext];

   always_ff @(posedge clk) begin
      if (wen)
         mem[idx] <= wdata;
      if (wen_ext)
         mem[idx_ext] <= wdata_ext;   // Later update wins on a collision
   end

endmodule

/* verif/cpu_tb.sv */
//****************************************
// Testbench with encoders, reference model,
// directed tests and watchdog
//****************************************
`timescale 1ns/1ps

module cpu_tb;

   localparam int PERIOD_NS       = 20;
   localparam int DMEM_WORDS      = 2 ** cpu_pkg::DMEM_ADDR_W;
   localparam int MAX_PROG        = 64;
   localparam int NUM_TESTS       = 5;
   // Reset, program load, data fill, run and full readback
   localparam int CYCLES_PER_TEST = 2 * DMEM_WORDS + 3 * MAX_PROG + 64;

   logic            clk;
   logic            reset;
   logic            enable;
   cpu_pkg::word_t  imem_addr_ext;
   logic            imem_wen_ext;
   cpu_pkg::instr_t imem_wdata_ext;
   cpu_pkg::instr_t imem_rdata_ext;
   cpu_pkg::word_t  dmem_addr_ext;
   logic            dmem_wen_ext;
   cpu_pkg::word_t  dmem_wdata_ext;
   cpu_pkg::word_t  dmem_rdata_ext;

   logic [31:0]     lfsr;
   cpu_pkg::instr_t prog [$];
   cpu_pkg::word_t  model_mem [DMEM_WORDS];
   int              checks;
   int              errors;
   int              tests_run;

   cpu_top UUT (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .imem_addr_ext  (imem_addr_ext),
      .imem_wen_ext   (imem_wen_ext),
      .imem_wdata_ext (imem_wdata_ext),
      .imem_rdata_ext (imem_rdata_ext),
      .dmem_addr_ext  (dmem_addr_ext),
      .dmem_wen_ext   (dmem_wen_ext),
      .dmem_wdata_ext (dmem_wdata_ext),
      .dmem_rdata_ext (dmem_rdata_ext)
   );

   always #(PERIOD_NS / 2) clk = ~clk;

   // Galois LFSR with taps 32 22 2 1
   function automatic logic next_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ 32'h80200003;
      return out;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
         r = {r[62:0], next_bit()};
      return r;
   endfunction

   // Doubleword aligned, signed 12 bit
   function automatic logic [11:0] rand_offset();
      logic [8:0] w;
      w = rand_bits(9);
      return {w, 3'b000};
   endfunction

   function automatic cpu_pkg::instr_t rtype_instr(input logic [6:0] f7, input logic [2:0] f3,
                                                   input cpu_pkg::reg_addr_t rd,
                                                   input cpu_pkg::reg_addr_t rs1,
                                                   input cpu_pkg::reg_addr_t rs2);
      return {f7, rs2, rs1, f3, rd, cpu_pkg::OP_RTYPE};
   endfunction

   function automatic cpu_pkg::instr_t add_instr(input cpu_pkg::reg_addr_t rd, rs1, rs2);
      return rtype_instr(7'b0000000, cpu_pkg::FUNCT3_ADD, rd, rs1, rs2);
   endfunction

   function automatic cpu_pkg::instr_t sub_instr(input cpu_pkg::reg_addr_t rd, rs1, rs2);
      return rtype_instr(cpu_pkg::FUNCT7_SUB, cpu_pkg::FUNCT3_ADD, rd, rs1, rs2);
   endfunction

   function automatic cpu_pkg::instr_t and_instr(input cpu_pkg::reg_addr_t rd, rs1, rs2);
      return rtype_instr(7'b0000000, cpu_pkg::FUNCT3_AND, rd, rs1, rs2);
   endfunction

   function automatic cpu_pkg::instr_t or_instr(input cpu_pkg::reg_addr_t rd, rs1, rs2);
      return rtype_instr(7'b0000000, cpu_pkg::FUNCT3_OR, rd, rs1, rs2);
   endfunction

   function automatic cpu_pkg::instr_t addi_instr(input cpu_pkg::reg_addr_t rd, rs1,
                                                  input logic [11:0] imm);
      return {imm, rs1, cpu_pkg::FUNCT3_ADD, rd, cpu_pkg::OP_IMM};
   endfunction

   function automatic cpu_pkg::instr_t ld_instr(input cpu_pkg::reg_addr_t rd, base,
                                                input logic [11:0] imm);
      return {imm, base, 3'b011, rd, cpu_pkg::OP_LOAD};
   endfunction

   // S-type keeps the low offset bits in the rd field
   function automatic cpu_pkg::instr_t sd_instr(input cpu_pkg::reg_addr_t src, base,
                                                input logic [11:0] imm);
      return {imm[11:5], src, base, 3'b011, imm[4:0], cpu_pkg::OP_STORE};
   endfunction

   function automatic cpu_pkg::instr_t nop_instr();
      return addi_instr(5'd0, 5'd0, 12'd0);
   endfunction

   task automatic add_nops(input int n);
      repeat (n)
         prog.push_back(nop_instr());
   endtask

   task automatic compare_word(input string name, input cpu_pkg::word_t expected, actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic compare_instr(input string name, input cpu_pkg::instr_t expected, actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before)
         $display("%-12s ok", name);
      else
         $display("%-12s %0d mismatches", name, errors - errs_before);
   endtask

   task automatic reset_dut();
      @(posedge clk);
      reset  <= 1'b1;
      enable <= 1'b0;
      repeat (2) @(posedge clk);
      reset  <= 1'b0;
   endtask

   task automatic write_imem(input cpu_pkg::word_t addr, input cpu_pkg::instr_t data);
      @(posedge clk);
      imem_addr_ext  <= addr;
      imem_wdata_ext <= data;
      imem_wen_ext   <= 1'b1;
      dmem_wen_ext   <= 1'b0;
   endtask

   task automatic write_dmem(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
      @(posedge clk);
      dmem_addr_ext  <= addr;
      dmem_wdata_ext <= data;
      dmem_wen_ext   <= 1'b1;
      imem_wen_ext   <= 1'b0;
   endtask

   task automatic end_host_writes();
      @(posedge clk);
      imem_wen_ext <= 1'b0;
      dmem_wen_ext <= 1'b0;
   endtask

   // Address set on the edge, data taken half a cycle later
   task automatic read_imem(input cpu_pkg::word_t addr, output cpu_pkg::instr_t data);
      @(posedge clk);
      imem_addr_ext <= addr;
      @(negedge clk);
      data = imem_rdata_ext;
   endtask

   task automatic read_dmem(input cpu_pkg::word_t addr, output cpu_pkg::word_t data);
      @(posedge clk);
      dmem_addr_ext <= addr;
      @(negedge clk);
      data = dmem_rdata_ext;
   endtask

   // Program padded with nops, data memory filled at random
   task automatic load_program();
      cpu_pkg::word_t fill;
      for (int i = 0; i < prog.size() + 16; i++)
         write_imem(i * 4, (i < prog.size()) ? prog[i] : nop_instr());
      for (int i = 0; i < DMEM_WORDS; i++) begin
         fill         = rand_bits(64);
         model_mem[i] = fill;
         write_dmem(i * 8, fill);
      end
      end_host_writes();
   endtask

   // Sequential interpreter of the RV64 subset
   task automatic model_execute();
      cpu_pkg::word_t  regs [32];
      cpu_pkg::instr_t ins;
      cpu_pkg::word_t  a;
      cpu_pkg::word_t  b;
      cpu_pkg::word_t  addr;
      cpu_pkg::word_t  imm_i;
      cpu_pkg::word_t  imm_s;
      foreach (regs[r])
         regs[r] = '0;
      foreach (prog[i]) begin
         ins   = prog[i];
         a     = regs[ins[19:15]];
         b     = regs[ins[24:20]];
         imm_i = {{52{ins[31]}}, ins[31:20]};
         imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
         case (ins[6:0])
            cpu_pkg::OP_RTYPE: begin
               case (ins[14:12])
                  cpu_pkg::FUNCT3_AND: regs[ins[11:7]] = a & b;
                  cpu_pkg::FUNCT3_OR:  regs[ins[11:7]] = a | b;
                  default: begin
                     if (ins[31:25] == cpu_pkg::FUNCT7_SUB)
                        regs[ins[11:7]] = a - b;
                     else
                        regs[ins[11:7]] = a + b;
                  end
               endcase
            end
            cpu_pkg::OP_IMM: regs[ins[11:7]] = a + imm_i;
            cpu_pkg::OP_LOAD: begin
               addr = a + imm_i;
               regs[ins[11:7]] = model_mem[addr[3 +: cpu_pkg::DMEM_ADDR_W]];
            end
            cpu_pkg::OP_STORE: begin
               addr = a + imm_s;
               model_mem[addr[3 +: cpu_pkg::DMEM_ADDR_W]] = b;
            end
            default: ;
         endcase
         regs[0] = '0;   // Hardwired zero
      end
   endtask

   task automatic run_enabled(input int n);
      @(posedge clk);
      enable <= 1'b1;
      repeat (n) @(posedge clk);
      enable <= 1'b0;
   endtask

   // Program length plus 12 enabled cycles with an optional pause
   task automatic run_core(input int pause_at, input int pause_len);
      int total;
      total = prog.size() + 12;
      if (pause_len > 0) begin
         run_enabled(pause_at);
         repeat (pause_len) @(posedge clk);
         run_enabled(total - pause_at);
      end else begin
         run_enabled(total);
      end
   endtask

   task automatic check_dmem(input string name);
      cpu_pkg::word_t got;
      for (int i = 0; i < DMEM_WORDS; i++) begin
         read_dmem(i * 8, got);
         compare_word(name, model_mem[i], got);
      end
   endtask

   task automatic run_program(input string name, input int pause_at, input int pause_len);
      int errs_before;
      errs_before = errors;
      reset_dut();
      load_program();
      model_execute();
      run_core(pause_at, pause_len);
      check_dmem(name);
      report_test(name, errs_before);
   endtask

   task automatic host_access_test();
      cpu_pkg::instr_t exp_instr [16];
      cpu_pkg::word_t  exp_word [16];
      cpu_pkg::instr_t got_instr;
      cpu_pkg::word_t  got_word;
      logic [8:0]      ibase;
      logic [9:0]      dbase;
      int              errs_before;
      errs_before = errors;
      ibase = rand_bits(9);
      dbase = rand_bits(10);
      for (int i = 0; i < 16; i++) begin
         exp_instr[i] = rand_bits(32);
         exp_word[i]  = rand_bits(64);
         write_imem((ibase + i) * 4, exp_instr[i]);
         write_dmem((dbase + i) * 8, exp_word[i]);
      end
      end_host_writes();
      for (int i = 0; i < 16; i++) begin
         read_imem((ibase + i) * 4, got_instr);
         compare_instr("host_access", exp_instr[i], got_instr);
         read_dmem((dbase + i) * 8, got_word);
         compare_word("host_access", exp_word[i], got_word);
      end
      report_test("host_access", errs_before);
   endtask

   task automatic alu_ops_test();
      cpu_pkg::reg_addr_t rd;
      prog.delete();
      prog.push_back(ld_instr(5'd1, 5'd0, rand_offset()));
      prog.push_back(ld_instr(5'd2, 5'd0, rand_offset()));
      add_nops(3);
      for (int k = 0; k < 5; k++) begin
         rd = 3 + k;
         case (k)
            0: prog.push_back(addi_instr(rd, 5'd1, rand_bits(12)));
            1: prog.push_back(add_instr(rd, 5'd1, 5'd2));
            2: prog.push_back(sub_instr(rd, 5'd1, 5'd2));
            3: prog.push_back(and_instr(rd, 5'd1, 5'd2));
            default: prog.push_back(or_instr(rd, 5'd1, 5'd2));
         endcase
         add_nops(3);
         prog.push_back(sd_instr(rd, 5'd0, rand_offset()));
         add_nops(1);
      end
      add_nops(3);
      run_program("alu_ops", 0, 0);
   endtask

   task automatic forwarding_test();
      prog.delete();
      prog.push_back(ld_instr(5'd1, 5'd0, rand_offset()));
      prog.push_back(ld_instr(5'd2, 5'd0, rand_offset()));
      add_nops(3);
      prog.push_back(add_instr(5'd3, 5'd1, 5'd2));
      prog.push_back(sub_instr(5'd4, 5'd3, 5'd1));    // Previous result
      prog.push_back(and_instr(5'd5, 5'd4, 5'd3));    // Previous and two before
      prog.push_back(or_instr(5'd6, 5'd5, 5'd4));
      prog.push_back(addi_instr(5'd7, 5'd6, rand_bits(12)));
      prog.push_back(add_instr(5'd8, 5'd7, 5'd5));
      prog.push_back(sd_instr(5'd8, 5'd0, rand_offset()));
      prog.push_back(sub_instr(5'd9, 5'd8, 5'd7));
      prog.push_back(sd_instr(5'd9, 5'd9, rand_offset()));   // Forwarded base and data
      for (int r = 3; r < 8; r++)
         prog.push_back(sd_instr(r, 5'd0, rand_offset()));
      add_nops(4);
      run_program("forwarding", 0, 0);
   endtask

   task automatic load_use_test();
      prog.delete();
      prog.push_back(ld_instr(5'd1, 5'd0, rand_offset()));
      prog.push_back(add_instr(5'd2, 5'd1, 5'd1));
      prog.push_back(sd_instr(5'd2, 5'd0, rand_offset()));
      prog.push_back(ld_instr(5'd3, 5'd0, rand_offset()));
      prog.push_back(sd_instr(5'd3, 5'd0, rand_offset()));
      prog.push_back(ld_instr(5'd4, 5'd1, rand_offset()));   // Random base address
      prog.push_back(ld_instr(5'd5, 5'd4, rand_offset()));
      prog.push_back(sd_instr(5'd5, 5'd1, rand_offset()));
      for (int k = 0; k < 4; k++) begin
         prog.push_back(ld_instr(10 + k, 5'd0, rand_offset()));
         prog.push_back(sd_instr(10 + k, 5'd0, rand_offset()));
      end
      add_nops(4);
      run_program("load_use", 0, 0);
   endtask

   task automatic x0_pause_test();
      prog.delete();
      prog.push_back(addi_instr(5'd0, 5'd0, rand_bits(12)));
      prog.push_back(ld_instr(5'd1, 5'd0, rand_offset()));
      add_nops(1);
      prog.push_back(add_instr(5'd0, 5'd1, 5'd1));
      prog.push_back(add_instr(5'd2, 5'd0, 5'd1));   // Must see x0 as zero
      prog.push_back(sd_instr(5'd0, 5'd0, rand_offset()));
      prog.push_back(sd_instr(5'd2, 5'd0, rand_offset()));
      prog.push_back(addi_instr(5'd3, 5'd2, rand_bits(12)));
      prog.push_back(sub_instr(5'd4, 5'd3, 5'd1));
      prog.push_back(sd_instr(5'd4, 5'd0, rand_offset()));
      add_nops(4);
      run_program("x0_pause", 4, 7);
   endtask

   initial begin
      clk            = 1'b0;
      reset          = 1'b0;
      enable         = 1'b0;
      imem_addr_ext  = '0;
      imem_wen_ext   = 1'b0;
      imem_wdata_ext = '0;
      dmem_addr_ext  = '0;
      dmem_wen_ext   = 1'b0;
      dmem_wdata_ext = '0;
      lfsr           = 32'hf9852abc;
      checks         = 0;
      errors         = 0;
      tests_run      = 0;
      host_access_test();
      alu_ops_test();
      forwarding_test();
      load_use_test();
      x0_pause_test();
      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   // Twice the cycle budget of all tests
   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * 2 * PERIOD_NS);
      $display("Watchdog expired before all tests finished");
      $display("TESTS FAILED");
      $finish;
   end

endmodule
